// File: common/pixelPipeline_cfg.svh
`ifndef PIXEL_PIPELINE_CFG_SVH
`define PIXEL_PIPELINE_CFG_SVH

// Colour channel and fragment sideband widths
`define SUB_PIXEL_WIDTH     8
`define INDEX_WIDTH         14
`define SCREEN_POS_WIDTH    11
`define DEPTH_WIDTH         32

// Texture sampling, S16.15 coordinates on a square power of two texture
`define TEX_COORD_WIDTH     32
`define TEX_SIZE_LOG2       7

// Fog table and its load stream
`define FOG_LUT_DEPTH_LOG2  5
`define CMD_STREAM_WIDTH    64

// Bit positions in the feature enable word
`define FEATURE_TMU_POS     0
`define FEATURE_FOG_POS     1

// Stage latencies in clock cycles
`define TMU_LATENCY         2
`define FOG_LATENCY         2

`endif

// File: common/PixelPkg.sv
`include "pixelPipeline_cfg.svh"

package PixelPkg;

    ////////////////////////////////////////
    // Plain vector types
    ////////////////////////////////////////
    typedef logic [`SUB_PIXEL_WIDTH - 1 : 0]        subPixelT;
    // RGBA, R in the top byte
    typedef logic [4 * `SUB_PIXEL_WIDTH - 1 : 0]    pixelT;
    // T in the upper half, S in the lower half
    typedef logic [2 * `TEX_SIZE_LOG2 - 1 : 0]      texAddrT;
    typedef logic [`TEX_COORD_WIDTH - 1 : 0]        texCoordT;
    // Q16.16
    typedef logic [`DEPTH_WIDTH - 1 : 0]            depthT;
    typedef logic [`SUB_PIXEL_WIDTH - 1 : 0]        fogFactorT;
    typedef logic [`CMD_STREAM_WIDTH - 1 : 0]       cmdWordT;

    // Value 3 is not a legal mode
    typedef enum logic [1 : 0]
    {
        REPLACE  = 2'd0,
        MODULATE = 2'd1,
        ADD      = 2'd2
    } texEnvModeE;

    ////////////////////////////////////////
    // Grouped signals
    ////////////////////////////////////////
    typedef struct packed
    {
        logic                               valid;
        logic                               last;
        logic                               keep;
        logic [`INDEX_WIDTH - 1 : 0]        index;
        logic [`SCREEN_POS_WIDTH - 1 : 0]   screenPosX;
        logic [`SCREEN_POS_WIDTH - 1 : 0]   screenPosY;
        depthT                              depth;
    } sidebandT;

    typedef struct packed
    {
        logic       enable;
        texEnvModeE mode;
    } tmuConfT;

    typedef struct packed
    {
        logic   enable;
        pixelT  fogColor;
    } fogConfT;

endpackage

// File: verilog/SidebandDelay.sv
`timescale 1ns/1ps

// Carries the fragment sideband alongside the colour stages
module SidebandDelay
#(
    parameter int Depth = 4
)
(
    input  logic                clk,
    input  logic                rst,
    input  PixelPkg::sidebandT  in,
    output PixelPkg::sidebandT  out
);

    PixelPkg::sidebandT stages [Depth];

    always_ff @(posedge clk)
    begin
        stages[0] <= in;
        for (int i = 1; i < Depth; i++)
        begin
            stages[i] <= stages[i - 1];
        end
        // Only the strobes are cleared, payload may hold stale values
        if (rst)
        begin
            for (int i = 0; i < Depth; i++)
            begin
                stages[i].valid <= 1'b0;
                stages[i].last  <= 1'b0;
            end
        end
    end

    assign out = stages[Depth - 1];

    // A last marker never leaves without a fragment
    lastNeedsValid: assert property (@(posedge clk) disable iff (rst)
        out.last |-> out.valid);

endmodule

// File: tmu/TexEnv.sv
`timescale 1ns/1ps
`include "pixelPipeline_cfg.svh"

// Texture environment, applied to each RGBA channel on its own
module TexEnv
(
    input  PixelPkg::texEnvModeE    mode,
    input  PixelPkg::pixelT         texel,
    input  PixelPkg::pixelT         primary,
    output PixelPkg::pixelT         result
);

    localparam int ChannelWidth = `SUB_PIXEL_WIDTH;
    localparam int Channels = 4;

    for (genvar ch = 0; ch < Channels; ch++)
    begin : gChannel
        PixelPkg::subPixelT texCh;
        PixelPkg::subPixelT primCh;
        PixelPkg::subPixelT addSat;
        logic [2 * ChannelWidth - 1 : 0] product;
        logic [ChannelWidth : 0] sum;

        assign texCh   = texel[ch * ChannelWidth +: ChannelWidth];
        assign primCh  = primary[ch * ChannelWidth +: ChannelWidth];
        assign product = texCh * primCh;
        assign sum     = texCh + primCh;

        // Clamp to full scale on carry out
        assign addSat = sum[ChannelWidth] ? {ChannelWidth{1'b1}} : sum[ChannelWidth - 1 : 0];

        // Anything other than modulate or add falls back to the texel
        assign result[ch * ChannelWidth +: ChannelWidth] =
            (mode == PixelPkg::MODULATE) ? product[2 * ChannelWidth - 1 : ChannelWidth] :
            (mode == PixelPkg::ADD)      ? addSat :
                                           texCh;
    end

endmodule

// File: tmu/TextureMappingUnit.sv
`timescale 1ns/1ps
`include "pixelPipeline_cfg.svh"

// Nearest texel sampling with a single texture environment stage
module TextureMappingUnit
(
    input  logic                    clk,
    input  logic                    rst,
    input  PixelPkg::tmuConfT       conf,
    input  PixelPkg::pixelT         primaryColor,
    input  PixelPkg::texCoordT      textureS,
    input  PixelPkg::texCoordT      textureT,
    output PixelPkg::texAddrT       texelAddr,
    input  PixelPkg::pixelT         texelColor,
    output PixelPkg::pixelT         texturedColor
);

    // Top fraction bit of an S16.15 coordinate
    localparam int FracMsb = 14;

    PixelPkg::pixelT primaryStage1;
    PixelPkg::pixelT envColor;

    ////////////////////////////////////////
    // Stage 1 address
    ////////////////////////////////////////
    // Integer part dropped, so the coordinates repeat across the texture
    always_ff @(posedge clk)
    begin
        texelAddr <= {
            textureT[FracMsb -: `TEX_SIZE_LOG2],
            textureS[FracMsb -: `TEX_SIZE_LOG2]
        };
        primaryStage1 <= primaryColor;
    end

    ////////////////////////////////////////
    // Stage 2 combine
    ////////////////////////////////////////
    // Texel arrives combinationally from the external memory
    TexEnv texEnv
    (
        .mode(conf.mode),
        .texel(texelColor),
        .primary(primaryStage1),
        .result(envColor)
    );

    always_ff @(posedge clk)
    begin
        if (conf.enable)
        begin
            texturedColor <= envColor;
        end
        else
        begin
            texturedColor <= primaryStage1;
        end
    end

    legalTexEnvMode: assert property (@(posedge clk) disable iff (rst)
        conf.mode != 2'd3);

endmodule

// File: fog/FogLut.sv
`timescale 1ns/1ps
`include "pixelPipeline_cfg.svh"

// Fog factor table, written from the command stream, read by depth
module FogLut
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    lutValid,
    input  logic                    lutLast,
    input  PixelPkg::cmdWordT       lutData,
    input  PixelPkg::depthT         depth,
    input  PixelPkg::pixelT         colorIn,
    output PixelPkg::fogFactorT     factor,
    output PixelPkg::pixelT         colorOut
);

    localparam int Entries = 1 << `FOG_LUT_DEPTH_LOG2;
    localparam int FactorsPerBeat = `CMD_STREAM_WIDTH / `SUB_PIXEL_WIDTH;
    localparam int BeatIdxWidth = $clog2(FactorsPerBeat);
    localparam int PtrWidth = `FOG_LUT_DEPTH_LOG2 - BeatIdxWidth;
    // Q16.16, integer part starts here
    localparam int DepthIntLsb = 16;

    PixelPkg::fogFactorT factorTable [Entries];
    logic [PtrWidth - 1 : 0] beatPtr;

    ////////////////////////////////////////
    // Stream loader
    ////////////////////////////////////////
    // Byte 0 of a beat lands on the lowest entry of its block
    always_ff @(posedge clk)
    begin
        if (lutValid)
        begin
            for (int i = 0; i < FactorsPerBeat; i++)
            begin
                factorTable[{beatPtr, BeatIdxWidth'(i)}] <=
                    lutData[i * `SUB_PIXEL_WIDTH +: `SUB_PIXEL_WIDTH];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            beatPtr <= '0;
        end
        else if (lutValid)
        begin
            beatPtr <= lutLast ? '0 : beatPtr + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        factor   <= factorTable[depth[DepthIntLsb +: `FOG_LUT_DEPTH_LOG2]];
        colorOut <= colorIn;
    end

    lastOnlyWithValid: assert property (@(posedge clk) disable iff (rst)
        lutLast |-> lutValid);

endmodule

// File: fog/FogBlend.sv
`timescale 1ns/1ps
`include "pixelPipeline_cfg.svh"

// Mixes the fragment colour towards the fog colour
module FogBlend
(
    input  logic                    clk,
    input  PixelPkg::fogConfT       conf,
    input  PixelPkg::fogFactorT     factor,
    input  PixelPkg::pixelT         color,
    output PixelPkg::pixelT         blended
);

    localparam int ChannelWidth = `SUB_PIXEL_WIDTH;
    localparam int Channels = 4;

    PixelPkg::pixelT fogged;
    logic [ChannelWidth : 0] invFactor;

    // 256 - factor, never zero
    assign invFactor = {1'b1, {ChannelWidth{1'b0}}} - {1'b0, factor};

    // Alpha is fogged too
    for (genvar ch = 0; ch < Channels; ch++)
    begin : gChannel
        PixelPkg::subPixelT colorCh;
        PixelPkg::subPixelT fogCh;
        logic [2 * ChannelWidth : 0] colorPart;
        logic [2 * ChannelWidth : 0] fogPart;
        logic [2 * ChannelWidth : 0] mix;

        assign colorCh   = color[ch * ChannelWidth +: ChannelWidth];
        assign fogCh     = conf.fogColor[ch * ChannelWidth +: ChannelWidth];
        assign colorPart = colorCh * factor;
        assign fogPart   = fogCh * invFactor;
        // Weights sum to 256 so the sum stays below 2^16
        assign mix       = colorPart + fogPart;

        assign fogged[ch * ChannelWidth +: ChannelWidth] =
            mix[2 * ChannelWidth - 1 : ChannelWidth];
    end

    always_ff @(posedge clk)
    begin
        blended <= conf.enable ? fogged : color;
    end

endmodule

// File: verilog/PixelPipeline.sv
`timescale 1ns/1ps
`include "pixelPipeline_cfg.svh"

// Fragment colour path: texture, then fog, sideband delayed to match
module PixelPipeline
(
    input  logic                    clk,
    input  logic                    rst,

    input  logic [31 : 0]           confFeatureEnable,
    input  PixelPkg::texEnvModeE    confTexEnvMode,
    input  PixelPkg::pixelT         confFogColor,

    input  logic                    fogLutValid,
    input  logic                    fogLutLast,
    input  PixelPkg::cmdWordT       fogLutData,

    input  PixelPkg::sidebandT      fragment,
    input  PixelPkg::pixelT         primaryColor,
    input  PixelPkg::texCoordT      textureS,
    input  PixelPkg::texCoordT      textureT,

    output PixelPkg::texAddrT       texelAddr,
    input  PixelPkg::pixelT         texelColor,

    output PixelPkg::sidebandT      framebuffer,
    output PixelPkg::pixelT         fragmentColor
);

    PixelPkg::tmuConfT  tmuConf;
    PixelPkg::fogConfT  fogConf;
    PixelPkg::sidebandT tmuSideband;
    PixelPkg::pixelT    texturedColor;
    PixelPkg::pixelT    lutColor;
    PixelPkg::fogFactorT fogFactor;

    assign tmuConf.enable   = confFeatureEnable[`FEATURE_TMU_POS];
    assign tmuConf.mode     = confTexEnvMode;
    assign fogConf.enable   = confFeatureEnable[`FEATURE_FOG_POS];
    assign fogConf.fogColor = confFogColor;

    ////////////////////////////////////////
    // Texture stage
    ////////////////////////////////////////
    TextureMappingUnit tmu
    (
        .clk(clk),
        .rst(rst),
        .conf(tmuConf),
        .primaryColor(primaryColor),
        .textureS(textureS),
        .textureT(textureT),
        .texelAddr(texelAddr),
        .texelColor(texelColor),
        .texturedColor(texturedColor)
    );

    // Split in two so the fog lookup sees the depth of its own fragment
    SidebandDelay #(.Depth(`TMU_LATENCY)) tmuDelay
    (
        .clk(clk),
        .rst(rst),
        .in(fragment),
        .out(tmuSideband)
    );

    ////////////////////////////////////////
    // Fog stage
    ////////////////////////////////////////
    FogLut fogLut
    (
        .clk(clk),
        .rst(rst),
        .lutValid(fogLutValid),
        .lutLast(fogLutLast),
        .lutData(fogLutData),
        .depth(tmuSideband.depth),
        .colorIn(texturedColor),
        .factor(fogFactor),
        .colorOut(lutColor)
    );

    FogBlend fogBlend
    (
        .clk(clk),
        .conf(fogConf),
        .factor(fogFactor),
        .color(lutColor),
        .blended(fragmentColor)
    );

    SidebandDelay #(.Depth(`FOG_LATENCY)) fogDelay
    (
        .clk(clk),
        .rst(rst),
        .in(tmuSideband),
        .out(framebuffer)
    );

endmodule

// File: tests/PixelPipelineTb.sv
`timescale 1ns/1ps
`include "pixelPipeline_cfg.svh"

module PixelPipelineTb;

    localparam int NumEntries = 20;
    localparam int PipeLatency = `TMU_LATENCY + `FOG_LATENCY;
    localparam int TimeoutCycles = NumEntries + 20 + 50;
    localparam int ChanW = `SUB_PIXEL_WIDTH;
    localparam PixelPkg::pixelT FogColor = 32'hB0C8E0FF;
    localparam logic [31 : 0] TmuOn = 32'h1 << `FEATURE_TMU_POS;
    localparam logic [31 : 0] FogOn = 32'h1 << `FEATURE_FOG_POS;

    typedef struct packed
    {
        PixelPkg::sidebandT sideband;
        PixelPkg::pixelT    color;
    } outT;

    typedef struct packed
    {
        PixelPkg::sidebandT     frag;
        PixelPkg::pixelT        primary;
        PixelPkg::texCoordT     s;
        PixelPkg::texCoordT     t;
        logic [31 : 0]          features;
        PixelPkg::texEnvModeE   mode;
        logic [1 : 0]           lutSet;
        PixelPkg::pixelT        expected;
    } stimT;

    logic                   clk;
    logic                   rst;
    logic [31 : 0]          confFeatureEnable;
    PixelPkg::texEnvModeE   confTexEnvMode;
    PixelPkg::pixelT        confFogColor;
    logic                   fogLutValid;
    logic                   fogLutLast;
    PixelPkg::cmdWordT      fogLutData;
    PixelPkg::sidebandT     fragment;
    PixelPkg::pixelT        primaryColor;
    PixelPkg::texCoordT     textureS;
    PixelPkg::texCoordT     textureT;
    PixelPkg::texAddrT      texelAddr;
    PixelPkg::pixelT        texelColor;
    PixelPkg::sidebandT     framebuffer;
    PixelPkg::pixelT        fragmentColor;

    stimT stimuli [$];
    outT expQ [$];
    int stampQ [$];
    stimT entry;
    outT expected;
    int stamp;
    int seed = 75;
    int loadedSet = 0;
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    int negCount = 0;
    logic addrArmed = 1'b0;
    PixelPkg::texAddrT addrExpected;

    PixelPipeline UUT
    (
        .clk(clk),
        .rst(rst),
        .confFeatureEnable(confFeatureEnable),
        .confTexEnvMode(confTexEnvMode),
        .confFogColor(confFogColor),
        .fogLutValid(fogLutValid),
        .fogLutLast(fogLutLast),
        .fogLutData(fogLutData),
        .fragment(fragment),
        .primaryColor(primaryColor),
        .textureS(textureS),
        .textureT(textureT),
        .texelAddr(texelAddr),
        .texelColor(texelColor),
        .framebuffer(framebuffer),
        .fragmentColor(fragmentColor)
    );

    ////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////
    // Texel memory contents depend on every address bit
    function automatic PixelPkg::pixelT texelAt(input PixelPkg::texAddrT addr);
        logic [15 : 0] a;
        a = {2'b00, addr};
        return {a[15 : 8] ^ 8'h3C, a[7 : 0] ^ 8'hC3, a[7 : 0] + a[15 : 8],
                ~a[7 : 0] ^ {a[13 : 8], 2'b01}};
    endfunction

    // Nearest texel from the fraction bits only so the texture repeats
    function automatic PixelPkg::texAddrT sampleAddr(input PixelPkg::texCoordT s,
                                                     input PixelPkg::texCoordT t);
        return {t[14 : 8], s[14 : 8]};
    endfunction

    function automatic PixelPkg::pixelT combine(input PixelPkg::texEnvModeE mode,
                                                input PixelPkg::pixelT texel,
                                                input PixelPkg::pixelT primary);
        PixelPkg::pixelT res;
        int te;
        int pr;
        int v;
        for (int ch = 0; ch < 4; ch++)
        begin
            te = texel[ch * ChanW +: ChanW];
            pr = primary[ch * ChanW +: ChanW];
            case (mode)
                PixelPkg::MODULATE: v = (te * pr) / 256;
                PixelPkg::ADD:      v = (te + pr > 255) ? 255 : te + pr;
                default:            v = te;
            endcase
            res[ch * ChanW +: ChanW] = v[7 : 0];
        end
        return res;
    endfunction

    function automatic PixelPkg::pixelT fogMix(input PixelPkg::pixelT color,
                                               input int factor,
                                               input PixelPkg::pixelT fog);
        PixelPkg::pixelT res;
        int c;
        int fc;
        int v;
        for (int ch = 0; ch < 4; ch++)
        begin
            c = color[ch * ChanW +: ChanW];
            fc = fog[ch * ChanW +: ChanW];
            v = (c * factor + fc * (256 - factor)) / 256;
            res[ch * ChanW +: ChanW] = v[7 : 0];
        end
        return res;
    endfunction

    // Set 3 is a short load that only exercises the last flag
    function automatic int factorOf(input int set, input int idx);
        case (set)
            1:       return (idx * 8 + 3) % 256;
            2:       return 255 - idx * 7;
            default: return (idx * 29 + 11) % 256;
        endcase
    endfunction

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////
    task automatic addEntry(input logic [31 : 0] features, input PixelPkg::texEnvModeE mode,
                            input int lutSet, input logic last, input logic keep,
                            input int depthInt, input PixelPkg::pixelT primary);
        stimT e;
        PixelPkg::pixelT color;
        e.frag.valid = 1'b1;
        e.frag.last = last;
        e.frag.keep = keep;
        e.frag.index = `INDEX_WIDTH'($random(seed));
        e.frag.screenPosX = `SCREEN_POS_WIDTH'($random(seed));
        e.frag.screenPosY = `SCREEN_POS_WIDTH'($random(seed));
        e.frag.depth = $random(seed);
        // Integer part of depth picks the fog entry
        e.frag.depth[16 +: `FOG_LUT_DEPTH_LOG2] = depthInt[4 : 0];
        e.primary = primary;
        e.s = $random(seed);
        e.t = $random(seed);
        e.features = features;
        e.mode = mode;
        e.lutSet = 2'(lutSet);
        color = primary;
        if (features[`FEATURE_TMU_POS])
        begin
            color = combine(mode, texelAt(sampleAddr(e.s, e.t)), primary);
        end
        if (features[`FEATURE_FOG_POS])
        begin
            color = fogMix(color, factorOf(lutSet, depthInt), FogColor);
        end
        e.expected = color;
        stimuli.push_back(e);
    endtask

    task automatic buildStimuli();
        addEntry(TmuOn, PixelPkg::REPLACE, 0, 1'b0, 1'b1, 3, $random(seed));
        addEntry(TmuOn, PixelPkg::REPLACE, 0, 1'b1, 1'b0, 9, $random(seed));
        addEntry(TmuOn, PixelPkg::REPLACE, 0, 1'b0, 1'b0, 17, $random(seed));
        addEntry(TmuOn, PixelPkg::MODULATE, 0, 1'b1, 1'b1, 2, $random(seed));
        addEntry(TmuOn, PixelPkg::MODULATE, 0, 1'b0, 1'b1, 5, $random(seed));
        addEntry(TmuOn, PixelPkg::MODULATE, 0, 1'b0, 1'b0, 28, 32'hFFFFFFFF);
        // Bright primary forces saturation on most channels
        addEntry(TmuOn, PixelPkg::ADD, 0, 1'b0, 1'b1, 4, 32'hF0F08010);
        addEntry(TmuOn, PixelPkg::ADD, 0, 1'b1, 1'b1, 6, $random(seed));
        addEntry(TmuOn, PixelPkg::ADD, 0, 1'b0, 1'b0, 11, 32'h00000000);
        addEntry(32'h0, PixelPkg::REPLACE, 0, 1'b0, 1'b1, 12, $random(seed));
        addEntry(32'h0, PixelPkg::REPLACE, 0, 1'b1, 1'b0, 21, $random(seed));
        addEntry(TmuOn | FogOn, PixelPkg::MODULATE, 1, 1'b0, 1'b1, 0, $random(seed));
        addEntry(TmuOn | FogOn, PixelPkg::MODULATE, 1, 1'b0, 1'b0, 7, $random(seed));
        addEntry(TmuOn | FogOn, PixelPkg::MODULATE, 1, 1'b0, 1'b1, 13, $random(seed));
        addEntry(TmuOn | FogOn, PixelPkg::MODULATE, 1, 1'b0, 1'b0, 24, $random(seed));
        addEntry(TmuOn | FogOn, PixelPkg::MODULATE, 1, 1'b1, 1'b1, 31, $random(seed));
        addEntry(FogOn, PixelPkg::REPLACE, 2, 1'b0, 1'b1, 1, $random(seed));
        addEntry(FogOn, PixelPkg::REPLACE, 2, 1'b0, 1'b0, 8, $random(seed));
        addEntry(FogOn, PixelPkg::REPLACE, 2, 1'b0, 1'b1, 19, $random(seed));
        addEntry(FogOn, PixelPkg::REPLACE, 2, 1'b1, 1'b1, 30, $random(seed));
    endtask

    task automatic waitDrained();
        while (expQ.size() != 0)
        begin
            @(posedge clk);
            fragment <= '0;
        end
    endtask

    // Eight factors per beat with the last flag on the final beat
    task automatic loadFogTable(input int set, input int beats);
        PixelPkg::cmdWordT data;
        for (int beat = 0; beat < beats; beat++)
        begin
            for (int k = 0; k < 8; k++)
            begin
                data[k * ChanW +: ChanW] = 8'(factorOf(set, beat * 8 + k));
            end
            @(posedge clk);
            fogLutValid <= 1'b1;
            fogLutLast <= (beat == beats - 1);
            fogLutData <= data;
        end
        @(posedge clk);
        fogLutValid <= 1'b0;
        fogLutLast <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Clock, memory model, timeout
    ////////////////////////////////////////
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(texelAddr)
    begin
        texelColor = texelAt(texelAddr);
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > TimeoutCycles)
        begin
            $display("Run did not finish within %0d cycles", TimeoutCycles);
            $display("Fragments checked: %0d, errors: %0d", checkCount, errorCount + 1);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////
    // Outputs are sampled on the falling edge
    always @(negedge clk)
    begin
        if (negCount > 0 && framebuffer.valid === 1'b1)
        begin
            if (expQ.size() == 0)
            begin
                errorCount++;
                $display("Output fragment at %0t while no fragment was in flight", $time);
            end
            else
            begin
                expected = expQ.pop_front();
                stamp = stampQ.pop_front();
                checkCount++;
                assert (framebuffer == expected.sideband) else
                begin
                    errorCount++;
                    $display("ERROR at %0t: framebuffer expected %h, got %h",
                             $time, expected.sideband, framebuffer);
                end
                assert (fragmentColor == expected.color) else
                begin
                    errorCount++;
                    $display("ERROR at %0t: fragmentColor expected %h, got %h",
                             $time, expected.color, fragmentColor);
                end
                assert (negCount - stamp == PipeLatency) else
                begin
                    errorCount++;
                    $display("ERROR at %0t: latency expected %0d, got %0d",
                             $time, PipeLatency, negCount - stamp);
                end
            end
        end
        else if (negCount > 0)
        begin
            assert (framebuffer.valid === 1'b0) else
            begin
                errorCount++;
                $display("framebuffer.valid is unknown at %0t", $time);
            end
        end
        if (addrArmed)
        begin
            assert (texelAddr == addrExpected) else
            begin
                errorCount++;
                $display("ERROR at %0t: texelAddr expected %h, got %h",
                         $time, addrExpected, texelAddr);
            end
        end
        // Inputs seen here are taken at the next rising edge
        addrArmed = !rst && fragment.valid;
        addrExpected = sampleAddr(textureS, textureT);
        if (!rst && fragment.valid)
        begin
            stampQ.push_back(negCount);
        end
        negCount++;
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial
    begin
        rst = 1'b1;
        confFeatureEnable = '0;
        confTexEnvMode = PixelPkg::REPLACE;
        confFogColor = FogColor;
        fogLutValid = 1'b0;
        fogLutLast = 1'b0;
        fogLutData = '0;
        fragment = '0;
        primaryColor = '0;
        textureS = '0;
        textureT = '0;
        texelColor = '0;
        buildStimuli();
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < stimuli.size(); i++)
        begin
            entry = stimuli[i];
            if (entry.lutSet != loadedSet)
            begin
                waitDrained();
                // A short load ending on last makes the full load restart at entry 0
                if (entry.lutSet == 2)
                begin
                    loadFogTable(3, 2);
                end
                loadFogTable(entry.lutSet, 4);
                loadedSet = entry.lutSet;
            end
            // Configuration only changes with the pipeline empty
            if (entry.features != confFeatureEnable || entry.mode != confTexEnvMode)
            begin
                waitDrained();
                confFeatureEnable <= entry.features;
                confTexEnvMode <= entry.mode;
            end
            @(posedge clk);
            fragment <= entry.frag;
            primaryColor <= entry.primary;
            textureS <= entry.s;
            textureT <= entry.t;
            expQ.push_back({entry.frag, entry.expected});
        end

        waitDrained();
        repeat (3) @(posedge clk);
        $display("Fragments checked: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: PixelPipeline.f
+incdir+common
common/PixelPkg.sv
verilog/SidebandDelay.sv
tmu/TexEnv.sv
tmu/TextureMappingUnit.sv
fog/FogLut.sv
fog/FogBlend.sv
verilog/PixelPipeline.sv
tests/PixelPipelineTb.sv

// File: Bender.yml
package:
  name: pixel_pipeline

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/PixelPkg.sv
      - verilog/SidebandDelay.sv
      - tmu/TexEnv.sv
      - tmu/TextureMappingUnit.sv
      - fog/FogLut.sv
      - fog/FogBlend.sv
      - verilog/PixelPipeline.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/PixelPipelineTb.sv
